// ==== rtl/pe_array.sv ====
`timescale 1ns/1ps

module pe_array (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_clear,
    input  logic                                    i_feed,
    input  sw_pkg::base_t                           i_ref_base,
    input  sw_pkg::query_t                          i_query,
    input  sw_pkg::bound_t                          i_bound,
    output sw_pkg::score_t [sw_pkg::NUM_PE-1:0]     o_diag_h,
    output logic           [sw_pkg::NUM_PE-1:0]     o_enable
);
    import sw_pkg::*;

    base_t [NUM_PE-1:0] ref_q;
    logic  [NUM_PE-1:0] en_q;
    logic  [NUM_PE-1:0] entering;
    query_t             query_q;
    cell_scores_t       cell_q [NUM_PE];
    cell_scores_t       pe_out [NUM_PE];
    score_t             diag_q [1:NUM_PE-1];

    // PE k starts its first column in the next cycle
    assign entering = {en_q[NUM_PE-2:0], i_feed} & ~en_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            en_q <= '0;
        end else if (i_clear) begin
            en_q <= '0;
        end else begin
            en_q <= {en_q[NUM_PE-2:0], i_feed};
        end
    end

    always_ff @(posedge i_clk) begin
        ref_q <= {ref_q[NUM_PE-2:0], i_ref_base};
        if (i_clear) begin
            query_q <= i_query;
        end
        for (int k = 0; k < NUM_PE; k++) begin
            if (i_clear) begin
                cell_q[k] <= '{h: NEG_INF, e: NEG_INF, f: NEG_INF};
            end else if (en_q[k]) begin
                cell_q[k] <= pe_out[k];
            end else if (entering[k]) begin
                // column 0 H, E stays at minus infinity
                cell_q[k].h <= i_bound.left_h;
            end
        end
        // top H one cycle late is the diagonal
        for (int k = 1; k < NUM_PE; k++) begin
            diag_q[k] <= i_clear ? NEG_INF : cell_q[k-1].h;
        end
    end

    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        cell_scores_t top;
        score_t       diag_in;

        if (k == 0) begin : g_head
            assign top     = '{h: i_bound.top_h, e: NEG_INF, f: i_bound.top_f};
            assign diag_in = i_bound.diag_h;
        end else begin : g_body
            assign top     = cell_q[k-1];
            assign diag_in = diag_q[k];
        end

        sw_pe pe_i (
            .i_query_base (query_q[k]),
            .i_ref_base   (ref_q[k]),
            .i_diag_h     (diag_in),
            .i_top        (top),
            .i_left       (cell_q[k]),
            .o_cell       (pe_out[k])
        );
    end

    always_comb begin
        for (int k = 0; k < NUM_PE; k++) begin
            o_diag_h[k] = pe_out[k].h;
        end
    end

    assign o_enable = en_q;

endmodule

// ==== rtl/stripe_ctrl.sv ====
`timescale 1ns/1ps

module stripe_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_start,
    input  logic                        i_ref_valid,
    input  sw_pkg::base_t               i_ref_base,
    input  sw_pkg::diag_stat_t          i_stat,
    input  logic [sw_pkg::NUM_PE-1:0]   i_enable,
    output logic                        o_clear,
    output logic                        o_feed,
    output sw_pkg::base_t               o_ref_base,
    output sw_pkg::bound_t              o_bound,
    output logic                        o_done,
    output sw_pkg::align_result_t       o_result
);
    import sw_pkg::*;

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    logic [POS_W-1:0] cnt_q;
    logic             ref_on_q;
    diag_stat_t       stat_q;
    logic             stat_vld_q;
    logic             stat_last_q;
    logic             eval;
    logic             improve;
    logic             drop;
    logic             stop;
    score_t           best_q;
    score_t           best_d;
    logic [POS_W-1:0] best_pos_q;
    logic [POS_W-1:0] best_pos_d;
    logic [ROW_W:0]   best_row_q;
    logic [ROW_W:0]   best_row_d;
    align_result_t    result_q;

    // H on row 0 and column 0, with H(0,0) = 0
    function automatic score_t edge_h(input logic [POS_W:0] n);
        int v;
        v = int'(GAP_OPEN) + int'(GAP_EXTEND) * int'(n);
        return (n == '0) ? score_t'(0) : score_t'(v);
    endfunction

    // cnt_q is the anti-diagonal index of the registered stat
    assign eval    = (state_q == CALC) && stat_vld_q;
    assign improve = eval && (stat_q.max_h > best_q);
    assign drop    = eval && (stat_q.max_h < best_q - XDROP);
    assign stop    = eval && (drop || stat_last_q);

    always_comb begin
        best_d     = best_q;
        best_pos_d = best_pos_q;
        best_row_d = best_row_q;
        if (improve) begin
            best_d     = stat_q.max_h;
            best_pos_d = cnt_q - POS_W'(stat_q.row) - POS_W'(1);
            best_row_d = {1'b0, stat_q.row} + 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (i_start) state_d = CALC;
            CALC:    if (stop) state_d = DONE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            ref_on_q    <= 1'b0;
            stat_vld_q  <= 1'b0;
            stat_last_q <= 1'b0;
            best_q      <= NEG_INF;
            best_pos_q  <= '0;
            best_row_q  <= '0;
            result_q    <= '0;
        end else begin
            state_q     <= state_d;
            stat_vld_q  <= (state_q == CALC) && (|i_enable);
            // only the last PE busy means the final anti-diagonal
            stat_last_q <= (i_enable == {1'b1, {(NUM_PE-1){1'b0}}});
            if (state_q == IDLE && i_start) begin
                cnt_q      <= '0;
                ref_on_q   <= 1'b1;
                best_q     <= NEG_INF;
                best_pos_q <= '0;
                best_row_q <= '0;
            end else if (state_q == CALC) begin
                cnt_q      <= cnt_q + 1'b1;
                best_q     <= best_d;
                best_pos_q <= best_pos_d;
                best_row_q <= best_row_d;
                if (!i_ref_valid) begin
                    ref_on_q <= 1'b0;
                end
                if (stop) begin
                    result_q <= '{best_score: best_d, best_pos: best_pos_d,
                                  best_row: best_row_d, steps: cnt_q, early_stop: drop};
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        stat_q <= i_stat;
    end

    assign o_clear    = (state_q == IDLE) && i_start;
    assign o_feed     = (state_q == CALC) && ref_on_q && i_ref_valid;
    assign o_ref_base = i_ref_base;

    // PE 0 works on column cnt_q, row cnt_q+1 is the next to start
    always_comb begin
        o_bound.top_h  = edge_h({1'b0, cnt_q});
        o_bound.top_f  = NEG_INF;
        o_bound.diag_h = edge_h({1'b0, cnt_q} - 1'b1);
        o_bound.left_h = edge_h({1'b0, cnt_q} + 1'b1);
    end

    assign o_done   = (state_q == DONE);
    assign o_result = result_q;

endmodule

// ==== rtl/sw_pe.sv ====
`timescale 1ns/1ps

module sw_pe (
    input  sw_pkg::base_t        i_query_base,
    input  sw_pkg::base_t        i_ref_base,
    input  sw_pkg::score_t       i_diag_h,
    input  sw_pkg::cell_scores_t i_top,
    input  sw_pkg::cell_scores_t i_left,
    output sw_pkg::cell_scores_t o_cell
);
    import sw_pkg::*;

    score_t sub_score;
    score_t e_open;
    score_t e_ext;
    score_t f_open;
    score_t f_ext;
    score_t h_diag;
    score_t e_val;
    score_t f_val;

    // add with a floor at NEG_INF so minus infinity stays put
    function automatic score_t sat_add(input score_t a, input score_t b);
        logic signed [SCORE_W:0] sum;
        sum = a + b;
        if (sum < NEG_INF) begin
            return NEG_INF;
        end
        return score_t'(sum);
    endfunction

    function automatic score_t smax(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        sub_score = (i_query_base == i_ref_base) ? MATCH_SCORE : MISMATCH_SCORE;

        // horizontal gap from the cell on the left
        e_open = sat_add(i_left.h, GAP_OPEN + GAP_EXTEND);
        e_ext  = sat_add(i_left.e, GAP_EXTEND);
        e_val  = smax(e_open, e_ext);

        // vertical gap from the row above
        f_open = sat_add(i_top.h, GAP_OPEN + GAP_EXTEND);
        f_ext  = sat_add(i_top.f, GAP_EXTEND);
        f_val  = smax(f_open, f_ext);

        h_diag = sat_add(i_diag_h, sub_score);

        o_cell.h = smax(h_diag, smax(e_val, f_val));
        o_cell.e = e_val;
        o_cell.f = f_val;
    end

endmodule

// ==== rtl/sw_pkg.sv ====
package sw_pkg;

    // array geometry and field widths
    localparam int NUM_PE  = 8;
    localparam int ROW_W   = 3;
    localparam int BASE_W  = 2;
    localparam int SCORE_W = 11;
    localparam int POS_W   = 7;

    typedef logic [BASE_W-1:0]         base_t;
    typedef logic signed [SCORE_W-1:0] score_t;

    // affine scoring, a gap of length L costs GAP_OPEN + L*GAP_EXTEND
    localparam score_t MATCH_SCORE    = score_t'(2);
    localparam score_t MISMATCH_SCORE = score_t'(-3);
    localparam score_t GAP_OPEN       = score_t'(-4);
    localparam score_t GAP_EXTEND     = score_t'(-1);
    localparam score_t XDROP          = score_t'(20);
    localparam score_t NEG_INF        = score_t'(-512);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } ctrl_state_e;

    // base k belongs to query row k+1
    typedef base_t [NUM_PE-1:0] query_t;

    typedef struct packed {
        score_t h;
        score_t e;
        score_t f;
    } cell_scores_t;

    // row 0 inputs of PE 0, plus the column 0 H of the row about to start
    typedef struct packed {
        score_t top_h;
        score_t top_f;
        score_t diag_h;
        score_t left_h;
    } bound_t;

    typedef struct packed {
        score_t           max_h;
        logic [ROW_W-1:0] row;
    } diag_stat_t;

    typedef struct packed {
        score_t           best_score;
        logic [POS_W-1:0] best_pos;
        logic [ROW_W:0]   best_row;
        logic [POS_W-1:0] steps;
        logic             early_stop;
    } align_result_t;

endpackage

// ==== rtl/sw_stripe_top.sv ====
`timescale 1ns/1ps

module sw_stripe_top (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  sw_pkg::query_t        i_query,
    input  logic                  i_ref_valid,
    input  sw_pkg::base_t         i_ref_base,
    output logic                  o_done,
    output sw_pkg::align_result_t o_result
);
    import sw_pkg::*;

    logic                clear;
    logic                feed;
    base_t               feed_base;
    bound_t              bound;
    score_t [NUM_PE-1:0] diag_h;
    logic   [NUM_PE-1:0] enable;
    diag_stat_t          stat;

    stripe_ctrl ctrl_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_ref_valid (i_ref_valid),
        .i_ref_base  (i_ref_base),
        .i_stat      (stat),
        .i_enable    (enable),
        .o_clear     (clear),
        .o_feed      (feed),
        .o_ref_base  (feed_base),
        .o_bound     (bound),
        .o_done      (o_done),
        .o_result    (o_result)
    );

    pe_array array_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_clear    (clear),
        .i_feed     (feed),
        .i_ref_base (feed_base),
        .i_query    (i_query),
        .i_bound    (bound),
        .o_diag_h   (diag_h),
        .o_enable   (enable)
    );

    wavefront_max wmax_i (
        .i_diag_h (diag_h),
        .i_enable (enable),
        .o_stat   (stat)
    );

endmodule

// ==== rtl/wavefront_max.sv ====
`timescale 1ns/1ps

module wavefront_max (
    input  sw_pkg::score_t [sw_pkg::NUM_PE-1:0] i_diag_h,
    input  logic           [sw_pkg::NUM_PE-1:0] i_enable,
    output sw_pkg::diag_stat_t                  o_stat
);
    import sw_pkg::*;

    // heap layout, leaves at NUM_PE..2*NUM_PE-1, root at 1
    score_t           node_h   [1:2*NUM_PE-1];
    logic [ROW_W-1:0] node_row [1:2*NUM_PE-1];

    for (genvar k = 0; k < NUM_PE; k++) begin : g_leaf
        // idle PEs never win
        assign node_h[NUM_PE+k]   = i_enable[k] ? i_diag_h[k] : NEG_INF;
        assign node_row[NUM_PE+k] = ROW_W'(k);
    end

    for (genvar n = NUM_PE - 1; n >= 1; n--) begin : g_node
        logic take_hi;

        // right child holds the higher rows, so ties go to it
        assign take_hi     = (node_h[2*n+1] >= node_h[2*n]);
        assign node_h[n]   = take_hi ? node_h[2*n+1] : node_h[2*n];
        assign node_row[n] = take_hi ? node_row[2*n+1] : node_row[2*n];
    end

    assign o_stat.max_h = node_h[1];
    assign o_stat.row   = node_row[1];

endmodule

// ==== tb/sw_props.sv ====
`timescale 1ns/1ps

module sw_props (
    input logic                  i_clk,
    input logic                  i_rst,
    input logic                  i_done,
    input sw_pkg::align_result_t i_result
);

    // done is a single-cycle strobe
    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |=> !i_done)
        else $error("o_done high for two cycles in a row");

    // result only moves together with done
    a_result_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_done |-> $stable(i_result))
        else $error("o_result changed without a done pulse");

    a_best_row: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |-> (i_result.best_row != '0))
        else $error("best row is zero while done is high");

endmodule

bind sw_stripe_top sw_props props_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_done   (o_done),
    .i_result (o_result)
);

// ==== tb/sw_tb.sv ====
`timescale 1ns/1ps

module sw_tb;
    import sw_pkg::*;

    localparam int DONE_TIMEOUT = 200;
    localparam int NUM_RANDOM   = 24;
    localparam int MAX_REF      = 64;

    logic          clk;
    logic          rst;
    logic          start;
    query_t        query;
    logic          ref_valid;
    base_t         ref_base;
    logic          done;
    align_result_t result;

    integer        seed = 32'hd43cee70;
    int            errors;
    int            checks;
    int            timeouts;
    int            done_pulses;
    bit            hung;
    align_result_t last_res;

    // model inputs, matrices and prediction
    query_t cur_query;
    base_t  ref_seq [1:MAX_REF];
    int     ref_len;
    int     h_m [0:NUM_PE][0:MAX_REF];
    int     e_m [0:NUM_PE][0:MAX_REF];
    int     f_m [0:NUM_PE][0:MAX_REF];
    int     exp_best;
    int     exp_row;
    int     exp_pos;
    int     exp_steps;
    bit     exp_early;

    tb_clkgen clkgen_i (
        .o_clk (clk),
        .o_rst (rst)
    );

    sw_stripe_top dut_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_start     (start),
        .i_query     (query),
        .i_ref_valid (ref_valid),
        .i_ref_base  (ref_base),
        .o_done      (done),
        .o_result    (result)
    );

    function automatic int max2(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    // advance to the next falling edge and count done strobes
    task automatic tick();
        @(negedge clk);
        if (done) begin
            done_pulses++;
        end
    endtask

    // fill H, E and F, then walk the anti-diagonals in order
    task automatic build_model();
        int open_ext;
        int best;
        int m;
        int m_row;
        int j;
        int sub;
        open_ext = int'(GAP_OPEN) + int'(GAP_EXTEND);
        h_m[0][0] = 0;
        for (int c = 1; c <= ref_len; c++) begin
            h_m[0][c] = int'(GAP_OPEN) + c * int'(GAP_EXTEND);
            f_m[0][c] = int'(NEG_INF);
        end
        for (int r = 1; r <= NUM_PE; r++) begin
            h_m[r][0] = int'(GAP_OPEN) + r * int'(GAP_EXTEND);
            e_m[r][0] = int'(NEG_INF);
            for (int c = 1; c <= ref_len; c++) begin
                sub = (cur_query[r-1] == ref_seq[c]) ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
                e_m[r][c] = max2(h_m[r][c-1] + open_ext, e_m[r][c-1] + int'(GAP_EXTEND));
                f_m[r][c] = max2(h_m[r-1][c] + open_ext, f_m[r-1][c] + int'(GAP_EXTEND));
                h_m[r][c] = max2(h_m[r-1][c-1] + sub, max2(e_m[r][c], f_m[r][c]));
            end
        end
        best = int'(NEG_INF);
        exp_row = 0;
        exp_pos = 0;
        exp_early = 1'b0;
        exp_steps = 0;
        for (int d = 2; d <= ref_len + NUM_PE; d++) begin
            m = int'(NEG_INF) - 1;
            m_row = 0;
            // higher row wins a tie within one diagonal
            for (int r = 1; r <= NUM_PE; r++) begin
                j = d - r;
                if (j >= 1 && j <= ref_len && h_m[r][j] >= m) begin
                    m = h_m[r][j];
                    m_row = r;
                end
            end
            exp_steps = d;
            if (m > best) begin
                best = m;
                exp_row = m_row;
                exp_pos = d - m_row;
            end else if (m < best - int'(XDROP)) begin
                exp_early = 1'b1;
                break;
            end
        end
        exp_best = best;
    endtask

    // start, stream the reference and wait for the done strobe
    task automatic run_alignment(input bit restart_mid);
        int            t;
        int            pulses_before;
        bit            seen;
        align_result_t res;
        build_model();
        pulses_before = done_pulses;
        start = 1'b1;
        query = cur_query;
        ref_valid = 1'b0;
        seen = 1'b0;
        t = 0;
        while (!seen && t < DONE_TIMEOUT) begin
            tick();
            start = 1'b0;
            if (done) begin
                seen = 1'b1;
                res = result;
            end else begin
                if (restart_mid && t == 2) begin
                    start = 1'b1;
                    query = ~cur_query;
                end
                if (t < ref_len) begin
                    ref_valid = 1'b1;
                    ref_base = ref_seq[t+1];
                end else if (t == ref_len) begin
                    ref_valid = 1'b0;
                    ref_base = base_t'($random(seed));
                end else begin
                    // bases after the end of the reference must be ignored
                    ref_valid = ($random(seed) & 1) != 0;
                    ref_base = base_t'($random(seed));
                end
            end
            t++;
        end
        ref_valid = 1'b0;
        if (!seen) begin
            $display("timeout: no done pulse within %0d cycles of the start", DONE_TIMEOUT);
            timeouts++;
            hung = 1'b1;
            return;
        end
        last_res = res;
        check_value("o_result.best_score", int'(res.best_score), exp_best);
        check_value("o_result.best_row", int'(res.best_row), exp_row);
        check_value("o_result.best_pos", int'(res.best_pos), exp_pos);
        check_value("o_result.steps", int'(res.steps), exp_steps);
        check_value("o_result.early_stop", int'(res.early_stop), int'(exp_early));
        if (res.best_row < 1 || res.best_row > NUM_PE ||
            res.best_pos < 1 || res.best_pos > ref_len) begin
            errors++;
            $display("reported best cell at row %0d position %0d lies outside the matrix",
                     res.best_row, res.best_pos);
        end else begin
            check_value("model H at reported cell", h_m[res.best_row][res.best_pos],
                        int'(res.best_score));
        end
        repeat (12) tick();
        check_value("o_done pulse count", done_pulses - pulses_before, 1);
    endtask

    initial begin
        int wait_cnt;
        start = 1'b0;
        query = '0;
        ref_valid = 1'b0;
        ref_base = '0;
        errors = 0;
        checks = 0;
        timeouts = 0;
        done_pulses = 0;
        hung = 1'b0;
        wait_cnt = 0;
        while (rst && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst) begin
            $display("timeout: reset was never released");
            timeouts++;
            hung = 1'b1;
        end

        if (!hung) begin
            // idle after reset
            for (int n = 0; n < 10; n++) begin
                tick();
                check_value("o_done", int'(done), 0);
                check_value("o_result", int'(result), 0);
            end
            // reference identical to the query
            cur_query = query_t'($random(seed));
            ref_len = NUM_PE;
            for (int k = 0; k < NUM_PE; k++) begin
                ref_seq[k+1] = cur_query[k];
            end
            run_alignment(1'b0);
        end
        if (!hung) begin
            check_value("o_result.best_score", int'(last_res.best_score),
                        NUM_PE * int'(MATCH_SCORE));
            check_value("o_result.best_row", int'(last_res.best_row), NUM_PE);
            check_value("o_result.best_pos", int'(last_res.best_pos), NUM_PE);
            check_value("o_result.early_stop", int'(last_res.early_stop), 0);

            // matching prefix, then a tail that matches no query base
            for (int k = 0; k < NUM_PE; k++) begin
                cur_query[k] = base_t'($random(seed) & 1);
            end
            ref_len = 48;
            for (int c = 1; c <= ref_len; c++) begin
                ref_seq[c] = (c <= NUM_PE) ? cur_query[c-1] : 2'd3;
            end
            run_alignment(1'b0);
        end
        if (!hung) begin
            check_value("o_result.early_stop", int'(last_res.early_stop), 1);
            check_value("o_result.steps below last diagonal",
                        int'(last_res.steps < ref_len + NUM_PE), 1);
        end

        for (int n = 0; n < NUM_RANDOM && !hung; n++) begin
            cur_query = query_t'($random(seed));
            ref_len = 1 + ({$random(seed)} % MAX_REF);
            for (int c = 1; c <= ref_len; c++) begin
                ref_seq[c] = base_t'($random(seed));
                // odd runs use a noisy copy of the query
                if (n % 2 == 1 && ($random(seed) & 3) != 0) begin
                    ref_seq[c] = cur_query[(c - 1) % NUM_PE];
                end
            end
            run_alignment(1'b1);
        end

        $display("closing report: %0d checks, %0d errors, %0d timeouts",
                 checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // reset spans four rising edges, released on a falling edge
    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// ==== vlog.f ====
rtl/sw_pkg.sv
rtl/sw_pe.sv
rtl/pe_array.sv
rtl/wavefront_max.sv
rtl/stripe_ctrl.sv
rtl/sw_stripe_top.sv
tb/tb_clkgen.sv
tb/sw_props.sv
tb/sw_tb.sv
